// ==== design/bft_pkg.sv ====
package bft_pkg;

    // packet layout on the tree bus
    //   [48]    valid
    //   [47:43] leaf id
    //   [42:39] port
    //   [38:32] address, or opcode for control packets
    //   [31:0]  payload
    localparam int PACKET_BITS  = 49;
    localparam int PAYLOAD_BITS = 32;
    localparam int LEAF_BITS    = 5;
    localparam int PORT_BITS    = 4;
    localparam int ADDR_BITS    = 7;

    // destination register holds a leaf id above a port number
    localparam int DEST_BITS = LEAF_BITS + PORT_BITS;

    localparam int VALID_BIT   = 48;
    localparam int LEAF_MSB    = 47;
    localparam int LEAF_LSB    = 43;
    localparam int PORT_MSB    = 42;
    localparam int PORT_LSB    = 39;
    localparam int ADDR_MSB    = 38;
    localparam int ADDR_LSB    = 32;
    localparam int PAYLOAD_MSB = 31;
    localparam int PAYLOAD_LSB = 0;

    // packets to this port carry an opcode instead of data
    localparam logic [PORT_BITS-1:0] CONTROL_PORT = 4'd0;

    typedef enum logic [ADDR_BITS-1:0] {
        OP_CREDIT   = 7'd1,
        OP_SET_DEST = 7'd2
    } bft_opcode_t;

endpackage

// ==== design/leaf_pkg.sv ====
package leaf_pkg;

    localparam int NUM_IN_PORTS  = 3;
    localparam int NUM_OUT_PORTS = 1;

    localparam int FIFO_DEPTH     = 16;
    localparam int FIFO_ADDR_BITS = 4;

    // width of the downstream credit counter and of the consumed-word counters
    localparam int CREDIT_BITS = 8;

    // one credit packet goes back to the host per chunk of consumed words
    localparam logic [CREDIT_BITS-1:0] CREDIT_CHUNK = 8'd8;

    localparam logic [bft_pkg::LEAF_BITS-1:0] OWN_LEAF  = 5'd5;
    localparam logic [bft_pkg::LEAF_BITS-1:0] HOST_LEAF = 5'd0;

    typedef enum logic [0:0] {
        S_COLLECT = 1'b0,
        S_OFFER   = 1'b1
    } kernel_state_t;

endpackage

// ==== design/port_fifo.sv ====
`timescale 1ns/1ps

module port_fifo (
    input  logic        clk,
    input  logic        reset,
    input  logic        wr_en,
    input  logic [31:0] wr_data,
    output logic        vld,
    output logic [31:0] data,
    input  logic        ack
);

    // pointers carry one extra wrap bit so that full and empty differ
    logic [leaf_pkg::FIFO_ADDR_BITS:0]   wr_ptr;
    logic [leaf_pkg::FIFO_ADDR_BITS:0]   rd_ptr;
    logic [31:0]                         mem [leaf_pkg::FIFO_DEPTH];
    logic                                empty;
    logic                                full;
    logic                                do_write;
    logic                                do_read;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[leaf_pkg::FIFO_ADDR_BITS] != rd_ptr[leaf_pkg::FIFO_ADDR_BITS]) &&
                   (wr_ptr[leaf_pkg::FIFO_ADDR_BITS-1:0] == rd_ptr[leaf_pkg::FIFO_ADDR_BITS-1:0]);

    assign do_write = wr_en && !full;
    assign do_read  = ack && !empty;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[leaf_pkg::FIFO_ADDR_BITS-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) wr_ptr <= wr_ptr + 1'b1;
            if (do_read)  rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // head of the queue is shown as soon as it is written
    assign vld  = !empty;
    assign data = mem[rd_ptr[leaf_pkg::FIFO_ADDR_BITS-1:0]];

endmodule

// ==== design/leaf_input_router.sv ====
`timescale 1ns/1ps

module leaf_input_router (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [bft_pkg::PACKET_BITS-1:0]     din_leaf_bft2interface,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0]   fifo_wr_en,
    output logic [bft_pkg::PAYLOAD_BITS-1:0]    fifo_wr_data_1,
    output logic [bft_pkg::PAYLOAD_BITS-1:0]    fifo_wr_data_2,
    output logic [bft_pkg::PAYLOAD_BITS-1:0]    fifo_wr_data_3,
    output logic [leaf_pkg::CREDIT_BITS-1:0]    credit_add,
    output logic                                credit_add_en,
    output logic [bft_pkg::DEST_BITS-1:0]       dest_addr,
    output logic                                dest_set_en
);

    logic                               pkt_valid;
    logic [bft_pkg::LEAF_BITS-1:0]      pkt_leaf;
    logic [bft_pkg::PORT_BITS-1:0]      pkt_port;
    bft_pkg::bft_opcode_t               pkt_op;
    logic [bft_pkg::PAYLOAD_BITS-1:0]   pkt_payload;
    logic                               accept;
    logic [bft_pkg::PAYLOAD_BITS-1:0]   payload_q;

    assign pkt_valid   = din_leaf_bft2interface[bft_pkg::VALID_BIT];
    assign pkt_leaf    = din_leaf_bft2interface[bft_pkg::LEAF_MSB:bft_pkg::LEAF_LSB];
    assign pkt_port    = din_leaf_bft2interface[bft_pkg::PORT_MSB:bft_pkg::PORT_LSB];
    assign pkt_op      = bft_pkg::bft_opcode_t'(
                             din_leaf_bft2interface[bft_pkg::ADDR_MSB:bft_pkg::ADDR_LSB]);
    assign pkt_payload = din_leaf_bft2interface[bft_pkg::PAYLOAD_MSB:bft_pkg::PAYLOAD_LSB];

    // anything not addressed to this leaf is ignored
    assign accept = pkt_valid && (pkt_leaf == leaf_pkg::OWN_LEAF);

    always_ff @(posedge clk) begin
        if (reset) begin
            fifo_wr_en    <= '0;
            credit_add_en <= 1'b0;
            dest_set_en   <= 1'b0;
        end else begin
            fifo_wr_en    <= '0;
            credit_add_en <= 1'b0;
            dest_set_en   <= 1'b0;
            if (accept) begin
                if (pkt_port == bft_pkg::CONTROL_PORT) begin
                    case (pkt_op)
                        bft_pkg::OP_CREDIT:   credit_add_en <= 1'b1;
                        bft_pkg::OP_SET_DEST: dest_set_en   <= 1'b1;
                        default: ;
                    endcase
                end else begin
                    // ports above the input count are dropped here
                    case (pkt_port)
                        4'd1:    fifo_wr_en <= 3'b001;
                        4'd2:    fifo_wr_en <= 3'b010;
                        4'd3:    fifo_wr_en <= 3'b100;
                        default: fifo_wr_en <= 3'b000;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            payload_q <= pkt_payload;
        end
    end

    assign fifo_wr_data_1 = payload_q;
    assign fifo_wr_data_2 = payload_q;
    assign fifo_wr_data_3 = payload_q;
    assign credit_add     = payload_q[leaf_pkg::CREDIT_BITS-1:0];
    assign dest_addr      = payload_q[bft_pkg::DEST_BITS-1:0];

endmodule

// ==== design/user_kernel.sv ====
`timescale 1ns/1ps

module user_kernel (
    input  logic        clk_user,
    input  logic        reset,
    input  logic [31:0] dout_leaf_interface2user_1,
    input  logic [31:0] dout_leaf_interface2user_2,
    input  logic [31:0] dout_leaf_interface2user_3,
    input  logic        vld_interface2user_1,
    input  logic        vld_interface2user_2,
    input  logic        vld_interface2user_3,
    output logic        ack_user2interface_1,
    output logic        ack_user2interface_2,
    output logic        ack_user2interface_3,
    output logic [31:0] din_leaf_user2interface_1,
    output logic        vld_user2interface_1,
    input  logic        ack_interface2user_1
);

    leaf_pkg::kernel_state_t state;
    logic                    running;
    logic                    take;
    logic [31:0]             sum_q;

    // the three words are joined only once every stream has one ready
    assign take = running && (state == leaf_pkg::S_COLLECT) &&
                  vld_interface2user_1 && vld_interface2user_2 && vld_interface2user_3;

    always_ff @(posedge clk_user) begin
        if (reset) begin
            state   <= leaf_pkg::S_COLLECT;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            case (state)
                leaf_pkg::S_COLLECT: if (take) state <= leaf_pkg::S_OFFER;
                leaf_pkg::S_OFFER:   if (ack_interface2user_1) state <= leaf_pkg::S_COLLECT;
                default:             state <= leaf_pkg::S_COLLECT;
            endcase
        end
    end

    // sum wraps at 32 bits
    always_ff @(posedge clk_user) begin
        if (take) begin
            sum_q <= dout_leaf_interface2user_1 + dout_leaf_interface2user_2 +
                     dout_leaf_interface2user_3;
        end
    end

    assign ack_user2interface_1      = take;
    assign ack_user2interface_2      = take;
    assign ack_user2interface_3      = take;
    assign din_leaf_user2interface_1 = sum_q;
    assign vld_user2interface_1      = (state == leaf_pkg::S_OFFER);

endmodule

// ==== design/leaf_output_packer.sv ====
`timescale 1ns/1ps

module leaf_output_packer (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [bft_pkg::PAYLOAD_BITS-1:0]    din_leaf_user2interface_1,
    input  logic                                vld_user2interface_1,
    output logic                                ack_interface2user_1,
    input  logic [leaf_pkg::NUM_IN_PORTS-1:0]   ack_user2interface,
    input  logic [leaf_pkg::CREDIT_BITS-1:0]    credit_add,
    input  logic                                credit_add_en,
    input  logic [bft_pkg::DEST_BITS-1:0]       dest_addr,
    input  logic                                dest_set_en,
    output logic [bft_pkg::PACKET_BITS-1:0]     dout_leaf_interface2bft
);

    logic [leaf_pkg::CREDIT_BITS-1:0]   credit_cnt;
    logic [leaf_pkg::CREDIT_BITS-1:0]   credit_inc;
    logic [leaf_pkg::CREDIT_BITS-1:0]   credit_dec;
    logic [bft_pkg::DEST_BITS-1:0]      dest_q;
    logic [leaf_pkg::CREDIT_BITS-1:0]   used_cnt [leaf_pkg::NUM_IN_PORTS];
    logic [leaf_pkg::NUM_IN_PORTS-1:0]  ret_pend;
    logic [1:0]                         ret_sel;
    logic                               send_data;
    logic [bft_pkg::PACKET_BITS-1:0]    pkt_q;

    // credit returns win over data so the host never starves
    assign send_data            = vld_user2interface_1 && (credit_cnt != '0) && (ret_pend == '0);
    assign ack_interface2user_1 = send_data;

    assign credit_inc = credit_add_en ? credit_add : '0;
    assign credit_dec = {{(leaf_pkg::CREDIT_BITS-1){1'b0}}, send_data};

    // lowest pending port goes first
    always_comb begin
        ret_sel = 2'd0;
        for (int i = leaf_pkg::NUM_IN_PORTS - 1; i >= 0; i--) begin
            if (ret_pend[i]) ret_sel = 2'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= '0;
            dest_q     <= '0;
            ret_pend   <= '0;
            pkt_q      <= '0;
            for (int i = 0; i < leaf_pkg::NUM_IN_PORTS; i++) used_cnt[i] <= '0;
        end else begin
            credit_cnt <= credit_cnt + credit_inc - credit_dec;
            if (dest_set_en) dest_q <= dest_addr;

            pkt_q <= '0;
            if (ret_pend != '0) begin
                ret_pend[ret_sel]                                    <= 1'b0;
                pkt_q[bft_pkg::VALID_BIT]                            <= 1'b1;
                pkt_q[bft_pkg::LEAF_MSB:bft_pkg::LEAF_LSB]           <= leaf_pkg::HOST_LEAF;
                pkt_q[bft_pkg::PORT_MSB:bft_pkg::PORT_LSB]           <= {2'b00, ret_sel} + 4'd1;
                pkt_q[bft_pkg::ADDR_MSB:bft_pkg::ADDR_LSB]           <= bft_pkg::OP_CREDIT;
                pkt_q[bft_pkg::PAYLOAD_MSB:bft_pkg::PAYLOAD_LSB]     <=
                    {{(bft_pkg::PAYLOAD_BITS-leaf_pkg::CREDIT_BITS){1'b0}}, leaf_pkg::CREDIT_CHUNK};
            end else if (send_data) begin
                pkt_q[bft_pkg::VALID_BIT]                            <= 1'b1;
                pkt_q[bft_pkg::LEAF_MSB:bft_pkg::LEAF_LSB]           <=
                    dest_q[bft_pkg::DEST_BITS-1:bft_pkg::PORT_BITS];
                pkt_q[bft_pkg::PORT_MSB:bft_pkg::PORT_LSB]           <=
                    dest_q[bft_pkg::PORT_BITS-1:0];
                pkt_q[bft_pkg::PAYLOAD_MSB:bft_pkg::PAYLOAD_LSB]     <= din_leaf_user2interface_1;
            end

            // a chunk of consumed words turns into one credit packet for that port
            for (int i = 0; i < leaf_pkg::NUM_IN_PORTS; i++) begin
                if (ack_user2interface[i]) begin
                    if (used_cnt[i] == leaf_pkg::CREDIT_CHUNK - 1'b1) begin
                        used_cnt[i] <= '0;
                        ret_pend[i] <= 1'b1;
                    end else begin
                        used_cnt[i] <= used_cnt[i] + 1'b1;
                    end
                end
            end
        end
    end

    assign dout_leaf_interface2bft = pkt_q;

endmodule

// ==== design/leaf_i3o1.sv ====
`timescale 1ns/1ps

module leaf_i3o1 (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [bft_pkg::PACKET_BITS-1:0] din_leaf_bft2interface,
    output logic [bft_pkg::PACKET_BITS-1:0] dout_leaf_interface2bft,
    input  logic                            resend,
    input  logic                            ap_start
);

    logic [leaf_pkg::NUM_IN_PORTS-1:0]  fifo_wr_en;
    logic [31:0]                        fifo_wr_data_1, fifo_wr_data_2, fifo_wr_data_3;
    logic [31:0]                        dout_leaf_interface2user_1;
    logic [31:0]                        dout_leaf_interface2user_2;
    logic [31:0]                        dout_leaf_interface2user_3;
    logic                               vld_interface2user_1, vld_interface2user_2;
    logic                               vld_interface2user_3;
    logic                               ack_user2interface_1, ack_user2interface_2;
    logic                               ack_user2interface_3;
    logic [31:0]                        din_leaf_user2interface_1;
    logic                               vld_user2interface_1;
    logic                               ack_interface2user_1;
    logic [leaf_pkg::CREDIT_BITS-1:0]   credit_add;
    logic                               credit_add_en;
    logic [bft_pkg::DEST_BITS-1:0]      dest_addr;
    logic                               dest_set_en;
    logic                               reset_ap_start_user;
    logic [bft_pkg::PACKET_BITS-1:0]    dout_leaf_interface2bft_tmp;

    // kernel stays in reset until the host starts it
    always_ff @(posedge clk) begin
        if (reset) reset_ap_start_user <= 1'b1;
        else if (ap_start) reset_ap_start_user <= 1'b0;
    end

    assign dout_leaf_interface2bft = resend ? '0 : dout_leaf_interface2bft_tmp;

    leaf_input_router router_inst (
        .clk(clk), .reset(reset), .din_leaf_bft2interface(din_leaf_bft2interface),
        .fifo_wr_en(fifo_wr_en), .fifo_wr_data_1(fifo_wr_data_1),
        .fifo_wr_data_2(fifo_wr_data_2), .fifo_wr_data_3(fifo_wr_data_3),
        .credit_add(credit_add), .credit_add_en(credit_add_en),
        .dest_addr(dest_addr), .dest_set_en(dest_set_en)
    );

    port_fifo fifo_1_inst (
        .clk(clk), .reset(reset), .wr_en(fifo_wr_en[0]), .wr_data(fifo_wr_data_1),
        .vld(vld_interface2user_1), .data(dout_leaf_interface2user_1),
        .ack(ack_user2interface_1)
    );

    port_fifo fifo_2_inst (
        .clk(clk), .reset(reset), .wr_en(fifo_wr_en[1]), .wr_data(fifo_wr_data_2),
        .vld(vld_interface2user_2), .data(dout_leaf_interface2user_2),
        .ack(ack_user2interface_2)
    );

    port_fifo fifo_3_inst (
        .clk(clk), .reset(reset), .wr_en(fifo_wr_en[2]), .wr_data(fifo_wr_data_3),
        .vld(vld_interface2user_3), .data(dout_leaf_interface2user_3),
        .ack(ack_user2interface_3)
    );

    user_kernel user_kernel_inst (
        .clk_user(clk), .reset(reset_ap_start_user),
        .dout_leaf_interface2user_1(dout_leaf_interface2user_1),
        .dout_leaf_interface2user_2(dout_leaf_interface2user_2),
        .dout_leaf_interface2user_3(dout_leaf_interface2user_3),
        .vld_interface2user_1(vld_interface2user_1),
        .vld_interface2user_2(vld_interface2user_2),
        .vld_interface2user_3(vld_interface2user_3),
        .ack_user2interface_1(ack_user2interface_1),
        .ack_user2interface_2(ack_user2interface_2),
        .ack_user2interface_3(ack_user2interface_3),
        .din_leaf_user2interface_1(din_leaf_user2interface_1),
        .vld_user2interface_1(vld_user2interface_1),
        .ack_interface2user_1(ack_interface2user_1)
    );

    leaf_output_packer packer_inst (
        .clk(clk), .reset(reset),
        .din_leaf_user2interface_1(din_leaf_user2interface_1),
        .vld_user2interface_1(vld_user2interface_1),
        .ack_interface2user_1(ack_interface2user_1),
        .ack_user2interface({ack_user2interface_3, ack_user2interface_2, ack_user2interface_1}),
        .credit_add(credit_add), .credit_add_en(credit_add_en),
        .dest_addr(dest_addr), .dest_set_en(dest_set_en),
        .dout_leaf_interface2bft(dout_leaf_interface2bft_tmp)
    );

endmodule

// ==== verification/leaf_i3o1_properties.sv ====
`timescale 1ns/1ps

module leaf_i3o1_properties (
    input logic                                clk,
    input logic                                reset,
    input logic [leaf_pkg::CREDIT_BITS-1:0]    credit_cnt,
    input logic [leaf_pkg::CREDIT_BITS-1:0]    credit_inc,
    input logic [bft_pkg::PACKET_BITS-1:0]     dout_leaf_interface2bft
);

    logic data_out;

    // a valid packet whose opcode field is not a credit return carries data
    assign data_out = dout_leaf_interface2bft[bft_pkg::VALID_BIT] &&
        (dout_leaf_interface2bft[bft_pkg::ADDR_MSB:bft_pkg::ADDR_LSB] != bft_pkg::OP_CREDIT);

    // an empty counter can only grow by the credits that arrive with it
    credit_no_wrap: assert property (@(posedge clk) disable iff (reset)
        (credit_cnt == '0) |=> (credit_cnt <= $past(credit_inc)))
        else $error("credit counter wrapped below zero");

    no_data_without_credit: assert property (@(posedge clk) disable iff (reset)
        data_out |-> ($past(credit_cnt) != '0))
        else $error("data packet sent with zero credits");

    valid_low_after_reset: assert property (@(posedge clk)
        reset |=> !dout_leaf_interface2bft[bft_pkg::VALID_BIT])
        else $error("output valid high in the cycle after reset");

endmodule

bind leaf_output_packer leaf_i3o1_properties props_inst (
    .clk(clk),
    .reset(reset),
    .credit_cnt(credit_cnt),
    .credit_inc(credit_inc),
    .dout_leaf_interface2bft(dout_leaf_interface2bft)
);

// ==== verification/leaf_i3o1_tb.sv ====
`timescale 1ns/1ps

module leaf_i3o1_tb;

    localparam logic [4:0] DEST_LEAF = 5'd9;
    localparam logic [3:0] DEST_PORT = 4'd2;
    localparam int         TIMEOUT   = 3000;

    logic        clk;
    logic        reset;
    logic [48:0] din_leaf_bft2interface;
    logic [48:0] dout_leaf_interface2bft;
    logic        resend;
    logic        ap_start;

    logic [48:0] expected_q[$];
    int          host_credit[1:3];
    int          returns_seen[1:3];
    int          data_seen;
    int          any_out;
    bit          started;
    int          checks;
    int          errors;

    leaf_i3o1 leaf_i3o1_inst (
        .clk(clk),
        .reset(reset),
        .din_leaf_bft2interface(din_leaf_bft2interface),
        .dout_leaf_interface2bft(dout_leaf_interface2bft),
        .resend(resend),
        .ap_start(ap_start)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] ref_sum(logic [31:0] a, logic [31:0] b, logic [31:0] c);
        return a + b + c;
    endfunction

    function automatic logic [48:0] make_pkt(logic v, logic [4:0] leaf, logic [3:0] port,
                                             logic [6:0] addr, logic [31:0] payload);
        return {v, leaf, port, addr, payload};
    endfunction

    task automatic check_eq(string name, logic [48:0] exp, logic [48:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_true(string what, bit cond);
        checks++;
        assert (cond) else begin
            errors++;
            $display("error: %s", what);
        end
    endtask

    task automatic abort_timeout(string what);
        errors++;
        $display("timeout while waiting for %s", what);
        $display("checks %0d, errors %0d", checks, errors);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic send_pkt(logic [48:0] pkt);
        @(posedge clk);
        din_leaf_bft2interface <= pkt;
        @(posedge clk);
        din_leaf_bft2interface <= '0;
    endtask

    task automatic send_word(int port, logic [31:0] word);
        int t;
        t = 0;
        while (host_credit[port] == 0) begin
            @(posedge clk);
            t++;
            if (t > TIMEOUT) abort_timeout("host credit");
        end
        host_credit[port]--;
        send_pkt(make_pkt(1'b1, leaf_pkg::OWN_LEAF, 4'(port), 7'd0, word));
    endtask

    task automatic send_triple(logic [31:0] a, logic [31:0] b, logic [31:0] c, bit record);
        if (record) expected_q.push_back(make_pkt(1'b1, DEST_LEAF, DEST_PORT, 7'd0,
                                                  ref_sum(a, b, c)));
        send_word(1, a);
        send_word(2, b);
        send_word(3, c);
    endtask

    task automatic send_control(bft_pkg::bft_opcode_t op, logic [31:0] payload);
        send_pkt(make_pkt(1'b1, leaf_pkg::OWN_LEAF, bft_pkg::CONTROL_PORT, op, payload));
    endtask

    task automatic wait_data(int n);
        int t;
        t = 0;
        while (data_seen < n) begin
            @(posedge clk);
            t++;
            if (t > TIMEOUT) abort_timeout("data packets");
        end
    endtask

    // this block models the host side of the tree and samples away from the driving edge
    always @(negedge clk) begin
        logic [3:0] port;
        if (resend) begin
            check_eq("resend zero", '0, dout_leaf_interface2bft);
        end else if (dout_leaf_interface2bft[bft_pkg::VALID_BIT]) begin
            any_out++;
            port = dout_leaf_interface2bft[bft_pkg::PORT_MSB:bft_pkg::PORT_LSB];
            if (dout_leaf_interface2bft[bft_pkg::LEAF_MSB:bft_pkg::LEAF_LSB] ==
                    leaf_pkg::HOST_LEAF &&
                    dout_leaf_interface2bft[bft_pkg::ADDR_MSB:bft_pkg::ADDR_LSB] ==
                    bft_pkg::OP_CREDIT) begin
                check_eq("credit payload", 49'(leaf_pkg::CREDIT_CHUNK),
                         49'(dout_leaf_interface2bft[31:0]));
                check_true("credit return names a port outside 1..3",
                           port >= 4'd1 && port <= 4'd3);
                if (port >= 4'd1 && port <= 4'd3) begin
                    returns_seen[port]++;
                    host_credit[port] += int'(leaf_pkg::CREDIT_CHUNK);
                end
            end else begin
                data_seen++;
                check_true("data packet before ap_start", started);
                if (expected_q.size() == 0) begin
                    check_true("data packet with nothing expected", 1'b0);
                end else begin
                    check_eq("data packet", expected_q.pop_front(), dout_leaf_interface2bft);
                end
            end
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        int          t;
        int          seen;
        void'($urandom(54698));
        reset = 1'b1;
        din_leaf_bft2interface = '0;
        resend = 1'b0;
        ap_start = 1'b0;
        started = 1'b0;
        data_seen = 0;
        any_out = 0;
        checks = 0;
        errors = 0;
        for (int p = 1; p <= 3; p++) begin
            host_credit[p] = leaf_pkg::FIFO_DEPTH;
            returns_seen[p] = 0;
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // words sit in all FIFOs while the kernel is still held
        send_triple(32'd1, 32'd2, 32'd3, 1'b1);
        send_triple(32'h10, 32'h20, 32'h30, 1'b1);
        send_triple(32'hFFFF_FFFF, 32'd1, 32'd5, 1'b1);
        send_control(bft_pkg::OP_SET_DEST, 32'({DEST_LEAF, DEST_PORT}));
        // two downstream credits are already there, so only the held kernel keeps sums back
        send_control(bft_pkg::OP_CREDIT, 32'd2);
        repeat (20) @(posedge clk);
        check_eq("outputs before ap_start", 49'd0, 49'(any_out));

        @(posedge clk);
        ap_start <= 1'b1;
        started = 1'b1;
        @(posedge clk);
        ap_start <= 1'b0;

        // two credits release two sums and the third waits at zero credits
        wait_data(2);
        repeat (20) @(posedge clk);
        check_eq("data after two credits", 49'd2, 49'(data_seen));
        send_control(bft_pkg::OP_CREDIT, 32'd200);

        for (int i = 0; i < 59; i++) begin
            a = $urandom;
            b = $urandom;
            c = $urandom;
            if (i % 7 == 2) begin
                a = 32'hFFFF_FFFF;
                c = 32'hFFFF_FFF0;
            end
            if (i == 20) begin
                send_pkt(make_pkt(1'b1, 5'd6, 4'd1, 7'd0, 32'hDEAD_BEEF));
                send_pkt(make_pkt(1'b0, leaf_pkg::OWN_LEAF, 4'd2, 7'd0, 32'hBAD0_0001));
            end
            send_triple(a, b, c, 1'b1);
        end

        t = 0;
        while (expected_q.size() != 0) begin
            @(posedge clk);
            t++;
            if (t > TIMEOUT) abort_timeout("all sums to drain");
        end
        repeat (20) @(posedge clk);
        for (int p = 1; p <= 3; p++) begin
            check_eq($sformatf("credit returns port %0d", p), 49'd7, 49'(returns_seen[p]));
        end

        // the sum produced while resend is high is lost on the bus
        seen = data_seen;
        @(posedge clk);
        resend <= 1'b1;
        send_triple(32'd7, 32'd8, 32'd9, 1'b0);
        repeat (30) @(posedge clk);
        resend <= 1'b0;
        repeat (10) @(posedge clk);
        check_eq("data seen across resend", 49'(seen), 49'(data_seen));

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== leaf_i3o1.f ====
design/bft_pkg.sv
design/leaf_pkg.sv
design/port_fifo.sv
design/leaf_input_router.sv
design/user_kernel.sv
design/leaf_output_packer.sv
design/leaf_i3o1.sv
verification/leaf_i3o1_properties.sv
verification/leaf_i3o1_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the leaf_i3o1 testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module leaf_i3o1_tb \
    -f leaf_i3o1.f \
    -o leaf_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/leaf_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

cat sim.log
if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
exit 0
